// File: Makefile
# Verilator build and run for the Curve25519 field multiplier

VERILATOR ?= verilator
TOP       ?= x25519_field_mult_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)
PASS_MSG  ?= Test completed successfully

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log is searched for the pass line, so a failing run returns non-zero
run: compile
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+include
source/x25519_pkg.sv
source/reduction_adder.sv
source/x25519_partial_products.sv
source/x25519_mult_pass.sv
source/x25519_mult_ctrl.sv
source/x25519_carry_reduce.sv
source/x25519_field_mult.sv
bench/x25519_field_mult_tb.sv

// File: bench/x25519_field_mult_tb.sv
module x25519_field_mult_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Cycles allowed from start to done
	localparam int DONE_TIMEOUT = 400;
	// p = 2^255 - 19
	localparam logic [255:0] P_FIELD = (256'd1 << 255) - 256'd19;

	logic            clk;
	logic            rst_n;
	logic            start;
	x25519_pkg::fe_t a;
	x25519_pkg::fe_t b;
	logic            busy;
	logic            done;
	x25519_pkg::fe_t result;

	int     mismatches;
	int     failures;
	integer seed;

	x25519_field_mult i_x25519_field_mult (
		.clk(clk), .rst_n(rst_n), .start(start), .a(a), .b(b),
		.busy(busy), .done(done), .result(result)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and checks

	// Full 512-bit product reduced mod p
	function automatic logic [255:0] mod_mult(input logic [255:0] x, input logic [255:0] y);
		logic [511:0] wide;
		wide = {256'd0, x} * {256'd0, y};
		wide = wide % {256'd0, P_FIELD};
		return wide[255:0];
	endfunction

	task automatic compare_fe(input string name, input x25519_pkg::fe_t expected,
		input x25519_pkg::fe_t actual);
		if (actual !== expected) begin
			mismatches++;
			$display("Mismatch at %0d ns: %s expected %h actual %h", $time, name, expected,
				actual);
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			mismatches++;
			$display("Mismatch at %0d ns: %s expected %b actual %b", $time, name, expected,
				actual);
		end
	endtask

	// Random field element with top bit cleared and reduced below p
	task automatic random_below_p(output logic [255:0] v);
		for (int k = 0; k < 8; k++)
			v[k*32 +: 32] = $random(seed);
		v[255] = 1'b0;
		if (v >= P_FIELD)
			v = v - P_FIELD;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	// One-cycle start pulse with operands
	task automatic start_mult(input logic [255:0] x, input logic [255:0] y);
		@(posedge clk);
		start <= 1'b1;
		a <= x;
		b <= y;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Returns at the falling edge inside the done cycle
	task automatic wait_done(output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < DONE_TIMEOUT) begin
			@(negedge clk);
			if (done === 1'b1)
				seen = 1'b1;
			cycles++;
		end
		if (!seen) begin
			failures++;
			$display("Timeout at %0d ns: no done pulse within %0d cycles", $time, DONE_TIMEOUT);
		end
	endtask

	task automatic check_mult(input logic [255:0] x, input logic [255:0] y,
		input logic [255:0] expected);
		bit           seen;
		logic [255:0] value;
		start_mult(x, y);
		wait_done(seen);
		if (seen) begin
			value = result;
			compare_fe("result", expected, result);
			// Canonical result lies strictly below p
			compare_bit("result_below_p", 1'b1, value < P_FIELD);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests

	// Idle outputs with no start
	task automatic reset_idle();
		for (int n = 0; n < 10; n++) begin
			@(negedge clk);
			compare_bit("busy", 1'b0, busy);
			compare_bit("done", 1'b0, done);
		end
	endtask

	// Non-wrapping slots only or zero everywhere
	task automatic small_operands();
		logic [255:0] x;
		random_below_p(x);
		check_mult(256'd2, 256'd3, 256'd6);
		check_mult(x, 256'd0, 256'd0);
		check_mult(256'd0, x, 256'd0);
		check_mult(256'd1, x, x);
	endtask

	// Heavy x38 scaling plus fold by 19 and final subtract
	task automatic wraparound();
		check_mult(P_FIELD - 256'd1, P_FIELD - 256'd1, 256'd1);
		check_mult(P_FIELD - 256'd1, 256'd2, P_FIELD - 256'd2);
		check_mult(P_FIELD - 256'd1, 256'd1, P_FIELD - 256'd1);
	endtask

	task automatic random_operands();
		logic [255:0] x;
		logic [255:0] y;
		for (int n = 0; n < 20; n++) begin
			random_below_p(x);
			random_below_p(y);
			check_mult(x, y, mod_mult(x, y));
		end
	endtask

	// Second start lands mid-issue and must be dropped
	task automatic ignored_start();
		logic [255:0]    x1;
		logic [255:0]    y1;
		logic [255:0]    x2;
		logic [255:0]    y2;
		int              pulses;
		x25519_pkg::fe_t first;
		random_below_p(x1);
		random_below_p(y1);
		random_below_p(x2);
		random_below_p(y2);
		first = '0;
		start_mult(x1, y1);
		repeat (6) @(posedge clk);
		@(negedge clk);
		compare_bit("busy", 1'b1, busy);
		start_mult(x2, y2);
		// Count every done pulse over a full window
		pulses = 0;
		for (int n = 0; n < DONE_TIMEOUT; n++) begin
			@(negedge clk);
			if (done === 1'b1) begin
				pulses++;
				if (pulses == 1)
					first = result;
			end
		end
		if (pulses != 1) begin
			failures++;
			$display("Expected exactly one done pulse after an ignored start, saw %0d at %0d ns",
				pulses, $time);
		end else begin
			compare_fe("result", mod_mult(x1, y1), first);
		end
		compare_bit("busy", 1'b0, busy);
	endtask

	// check_mult returns inside the done cycle so the next start follows directly
	task automatic back_to_back();
		logic [255:0] x1;
		logic [255:0] y1;
		logic [255:0] x2;
		logic [255:0] y2;
		random_below_p(x1);
		random_below_p(y1);
		random_below_p(x2);
		random_below_p(y2);
		check_mult(x1, y1, mod_mult(x1, y1));
		check_mult(x2, y2, mod_mult(x2, y2));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		seed = 32'h1de6_cc67;
		mismatches = 0;
		failures = 0;
		rst_n = 1'b0;
		start = 1'b0;
		a = '0;
		b = '0;
		// Two cycles of reset
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		reset_idle();
		small_operands();
		wraparound();
		random_operands();
		ignored_start();
		back_to_back();
		$display("Error count: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: include/x25519_cfg.svh
`ifndef X25519_CFG_SVH
`define X25519_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Field element geometry

// Limbs per field element
`define X25519_LIMBS 32

// Radix bits per limb
`define X25519_LIMB_W 8

// Partial product and accumulator word
`define X25519_WORD_W 32

`endif

// File: source/reduction_adder.sv
module reduction_adder #(
	parameter int IN_WORD_WIDTH  = 32,
	parameter int OUT_WORD_WIDTH = 32,
	parameter int IN_BLOCKS      = 32,
	parameter int REDUCTION      = 4
) (
	input  logic                                             clk,
	input  logic                                             rst_n,
	input  logic                                             en,
	input  logic [IN_WORD_WIDTH*IN_BLOCKS-1:0]               din,
	output logic                                             dout_valid,
	output logic [OUT_WORD_WIDTH*(IN_BLOCKS/REDUCTION)-1:0] dout
);

	// Words left after this stage
	localparam int OUT_BLOCKS = IN_BLOCKS / REDUCTION;

	logic [OUT_BLOCKS-1:0][OUT_WORD_WIDTH-1:0] group_sum;

	////////////////////////////////////////////////////////////////////////
	// Group adders

	// Each output word sums REDUCTION adjacent inputs
	always_comb begin
		for (int g = 0; g < OUT_BLOCKS; g++) begin
			group_sum[g] = '0;
			for (int k = 0; k < REDUCTION; k++) begin
				group_sum[g] = group_sum[g] +
					OUT_WORD_WIDTH'(din[(g*REDUCTION+k)*IN_WORD_WIDTH +: IN_WORD_WIDTH]);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Output register

	// One cycle of delay on the strobe
	always_ff @(posedge clk) begin
		if (!rst_n)
			dout_valid <= 1'b0;
		else
			dout_valid <= en;
	end

	// Payload only moves with a valid input
	always_ff @(posedge clk) begin
		if (en)
			dout <= group_sum;
	end

endmodule

// File: source/x25519_carry_reduce.sv
`include "x25519_cfg.svh"

module x25519_carry_reduce (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  load,
	input  x25519_pkg::bignum32_t sums,
	output logic                  done,
	output x25519_pkg::fe_t       result
);

	// p = 2^255 - 19
	localparam logic [`X25519_LIMBS*`X25519_LIMB_W-1:0] P_MOD = (256'd1 << 255) - 256'd19;

	x25519_pkg::reduce_state_t                state;
	x25519_pkg::bignum32_t                    acc;
	logic [4:0]                               idx;
	logic [`X25519_WORD_W-1:0]                carry;
	logic [`X25519_WORD_W-1:0]                t;
	logic [`X25519_LIMBS*`X25519_LIMB_W-1:0]  flat;

	// Current limb plus running carry
	assign t = acc.blocks[idx] + carry;

	// Low byte of each limb, packed into one number
	always_comb begin
		for (int k = 0; k < `X25519_LIMBS; k++)
			flat[k*`X25519_LIMB_W +: `X25519_LIMB_W] = acc.blocks[k][`X25519_LIMB_W-1:0];
	end

	////////////////////////////////////////////////////////////////////////
	// Carry FSM, one limb per cycle

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= x25519_pkg::RED_IDLE;
			idx <= 5'd0;
			carry <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				x25519_pkg::RED_IDLE: if (load) begin
					state <= x25519_pkg::RED_CARRY1;
					idx <= 5'd0;
					carry <= '0;
				end
				x25519_pkg::RED_CARRY1, x25519_pkg::RED_CARRY2: begin
					idx <= idx + 5'd1;
					carry <= t >> 8;
					// Top limb of pass one keeps 7 bits, rest folds back by 19
					if (idx == 5'd31 && state == x25519_pkg::RED_CARRY1) begin
						carry <= (t >> 7) * 32'd19;
						state <= x25519_pkg::RED_CARRY2;
					end else if (idx == 5'd31) begin
						// Small enough here to stay in limb 31
						carry <= '0;
						state <= x25519_pkg::RED_FINAL;
					end
				end
				// Value is below 2p, one subtract is enough
				x25519_pkg::RED_FINAL: begin
					done <= 1'b1;
					state <= x25519_pkg::RED_IDLE;
				end
				default: state <= x25519_pkg::RED_IDLE;
			endcase
		end
	end

	// Limb and result payload
	always_ff @(posedge clk) begin
		if (state == x25519_pkg::RED_IDLE && load)
			acc <= sums;
		else if (state == x25519_pkg::RED_CARRY1 && idx == 5'd31)
			acc.blocks[idx] <= {{(`X25519_WORD_W-7){1'b0}}, t[6:0]};
		else if (state == x25519_pkg::RED_CARRY1 || state == x25519_pkg::RED_CARRY2)
			acc.blocks[idx] <= {{(`X25519_WORD_W-`X25519_LIMB_W){1'b0}}, t[7:0]};
		if (state == x25519_pkg::RED_FINAL)
			result <= (flat >= P_MOD) ? flat - P_MOD : flat;
	end

endmodule

// File: source/x25519_field_mult.sv
`include "x25519_cfg.svh"

module x25519_field_mult (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,
	input  x25519_pkg::fe_t a,
	input  x25519_pkg::fe_t b,
	output logic            busy,
	output logic            done,
	output x25519_pkg::fe_t result
);

	// Controller to pass unit
	logic                      pass_en;
	logic [4:0]                pass_i;
	x25519_pkg::bignum_t       pass_a;
	x25519_pkg::bignum_t       pass_b;
	logic                      pass_valid;
	logic [`X25519_WORD_W-1:0] pass_sum;

	// Controller to carry unit
	logic                      load;
	x25519_pkg::bignum32_t     sums;

	x25519_mult_ctrl i_mult_ctrl (
		.clk(clk), .rst_n(rst_n), .start(start), .a(a), .b(b), .busy(busy),
		.pass_en(pass_en), .pass_i(pass_i), .pass_a(pass_a), .pass_b(pass_b),
		.pass_valid(pass_valid), .pass_sum(pass_sum),
		.load(load), .sums(sums), .done(done)
	);

	x25519_mult_pass i_mult_pass (
		.clk(clk), .rst_n(rst_n), .en(pass_en), .i(pass_i), .a(pass_a), .b(pass_b),
		.out_valid(pass_valid), .out(pass_sum)
	);

	x25519_carry_reduce i_carry_reduce (
		.clk(clk), .rst_n(rst_n), .load(load), .sums(sums),
		.done(done), .result(result)
	);

endmodule

// File: source/x25519_mult_ctrl.sv
`include "x25519_cfg.svh"

module x25519_mult_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  x25519_pkg::fe_t            a,
	input  x25519_pkg::fe_t            b,
	output logic                       busy,
	output logic                       pass_en,
	output logic [4:0]                 pass_i,
	output x25519_pkg::bignum_t        pass_a,
	output x25519_pkg::bignum_t        pass_b,
	input  logic                       pass_valid,
	input  logic [`X25519_WORD_W-1:0]  pass_sum,
	output logic                       load,
	output x25519_pkg::bignum32_t      sums,
	input  logic                       done
);

	x25519_pkg::ctrl_state_t state;
	x25519_pkg::fe_t         a_reg;
	x25519_pkg::fe_t         b_reg;
	logic [4:0]              issue_idx;
	logic [4:0]              ret_idx;
	x25519_pkg::bignum32_t   sum_buf;

	////////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= x25519_pkg::CTRL_IDLE;
			issue_idx <= 5'd0;
			ret_idx <= 5'd0;
			load <= 1'b0;
		end else begin
			load <= 1'b0;
			// Sums come back in issue order
			if (pass_valid)
				ret_idx <= ret_idx + 5'd1;
			case (state)
				x25519_pkg::CTRL_IDLE: if (start) begin
					state <= x25519_pkg::CTRL_ISSUE;
					issue_idx <= 5'd0;
					ret_idx <= 5'd0;
				end
				x25519_pkg::CTRL_ISSUE: begin
					issue_idx <= issue_idx + 5'd1;
					if (issue_idx == 5'd31)
						state <= x25519_pkg::CTRL_COLLECT;
				end
				// Last sum lands in the buffer as load goes high
				x25519_pkg::CTRL_COLLECT: if (pass_valid && ret_idx == 5'd31) begin
					state <= x25519_pkg::CTRL_REDUCE;
					load <= 1'b1;
				end
				x25519_pkg::CTRL_REDUCE: if (done)
					state <= x25519_pkg::CTRL_IDLE;
				default: state <= x25519_pkg::CTRL_IDLE;
			endcase
		end
	end

	// Operand latch and result buffer
	always_ff @(posedge clk) begin
		if (state == x25519_pkg::CTRL_IDLE && start) begin
			a_reg <= a;
			b_reg <= b;
		end
		if (pass_valid)
			sum_buf.blocks[ret_idx] <= pass_sum;
	end

	////////////////////////////////////////////////////////////////////////
	// Pass operands

	// Slot j gets b limb (i - j) mod 32, wraps for free in 5 bits
	always_comb begin
		logic [4:0] src;
		for (int j = 0; j < `X25519_LIMBS; j++) begin
			src = issue_idx - 5'(j);
			pass_a.blocks[j] = {{(`X25519_WORD_W-`X25519_LIMB_W){1'b0}}, a_reg.blocks[j]};
			pass_b.blocks[j] = {{(`X25519_WORD_W-`X25519_LIMB_W){1'b0}}, b_reg.blocks[src]};
		end
	end

	assign pass_en = (state == x25519_pkg::CTRL_ISSUE);
	assign pass_i = issue_idx;
	assign sums = sum_buf;
	assign busy = (state != x25519_pkg::CTRL_IDLE);

endmodule

// File: source/x25519_mult_pass.sv
`include "x25519_cfg.svh"

module x25519_mult_pass (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       en,
	input  logic [4:0]                 i,
	input  x25519_pkg::bignum_t        a,
	input  x25519_pkg::bignum_t        b,
	output logic                       out_valid,
	output logic [`X25519_WORD_W-1:0]  out
);

	// Scaled products, two cycles after en
	logic                    prod_en;
	x25519_pkg::bignum32_t   prod;

	// Tree intermediates, 8 words then 2
	logic                        tree8_en;
	logic [`X25519_WORD_W*8-1:0] tree8;
	logic                        tree2_en;
	logic [`X25519_WORD_W*2-1:0] tree2;

	x25519_partial_products i_partial_products (
		.clk(clk), .rst_n(rst_n), .en(en), .i(i), .a(a), .b(b),
		.prod_en(prod_en), .prod(prod)
	);

	////////////////////////////////////////////////////////////////////////
	// Adder tree, fan-in of 4 per stage

	reduction_adder #(
		.IN_WORD_WIDTH(`X25519_WORD_W), .OUT_WORD_WIDTH(`X25519_WORD_W),
		.IN_BLOCKS(32), .REDUCTION(4)
	) i_tree32 (
		.clk(clk), .rst_n(rst_n), .en(prod_en), .din(prod),
		.dout_valid(tree8_en), .dout(tree8)
	);

	reduction_adder #(
		.IN_WORD_WIDTH(`X25519_WORD_W), .OUT_WORD_WIDTH(`X25519_WORD_W),
		.IN_BLOCKS(8), .REDUCTION(4)
	) i_tree8 (
		.clk(clk), .rst_n(rst_n), .en(tree8_en), .din(tree8),
		.dout_valid(tree2_en), .dout(tree2)
	);

	// Last stage only has two words left
	reduction_adder #(
		.IN_WORD_WIDTH(`X25519_WORD_W), .OUT_WORD_WIDTH(`X25519_WORD_W),
		.IN_BLOCKS(2), .REDUCTION(2)
	) i_tree2 (
		.clk(clk), .rst_n(rst_n), .en(tree2_en), .din(tree2),
		.dout_valid(out_valid), .dout(out)
	);

endmodule

// File: source/x25519_partial_products.sv
`include "x25519_cfg.svh"

module x25519_partial_products (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  en,
	input  logic [4:0]            i,
	input  x25519_pkg::bignum_t   a,
	input  x25519_pkg::bignum_t   b,
	output logic                  prod_en,
	output x25519_pkg::bignum32_t prod
);

	// Stage one results
	logic                     stage1_en;
	x25519_pkg::bignum32_t    stage1_prod;
	logic [`X25519_LIMBS-1:0] stage1_wrap;

	// Valid strobe follows the data, one flop per stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage1_en <= 1'b0;
			prod_en <= 1'b0;
		end else begin
			stage1_en <= en;
			prod_en <= stage1_en;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Stage one, limb products

	always_ff @(posedge clk) begin
		if (en) begin
			for (int j = 0; j < `X25519_LIMBS; j++) begin
				stage1_prod.blocks[j] <= a.blocks[j] * b.blocks[j];
				// Slot wraps past limb 31 when j > i
				stage1_wrap[j] <= (j > i);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Stage two, scale wrapped slots

	// 2^256 = 38 mod p
	always_ff @(posedge clk) begin
		if (stage1_en) begin
			for (int j = 0; j < `X25519_LIMBS; j++) begin
				if (stage1_wrap[j])
					prod.blocks[j] <= stage1_prod.blocks[j] * 32'd38;
				else
					prod.blocks[j] <= stage1_prod.blocks[j];
			end
		end
	end

endmodule

// File: source/x25519_pkg.sv
package x25519_pkg;

	`include "x25519_cfg.svh"

	////////////////////////////////////////////////////////////////////////
	// Operand and intermediate types

	// Canonical field element, limb 0 in the low bits
	typedef struct packed {
		logic [`X25519_LIMBS-1:0][`X25519_LIMB_W-1:0] blocks;
	} fe_t;

	// Operand limbs widened to a full word
	typedef struct packed {
		logic [`X25519_LIMBS-1:0][`X25519_WORD_W-1:0] blocks;
	} bignum_t;

	// Scaled products and pass sums, wider than one limb
	typedef struct packed {
		logic [`X25519_LIMBS-1:0][`X25519_WORD_W-1:0] blocks;
	} bignum32_t;

	////////////////////////////////////////////////////////////////////////
	// FSM states

	typedef enum logic [1:0] {CTRL_IDLE, CTRL_ISSUE, CTRL_COLLECT, CTRL_REDUCE} ctrl_state_t;

	typedef enum logic [1:0] {RED_IDLE, RED_CARRY1, RED_CARRY2, RED_FINAL} reduce_state_t;

endpackage
